//--- vlog.f
rtl/l1i_pkg.sv
rtl/icache_if.sv
rtl/icache_arrays.sv
rtl/fetch_queue.sv
rtl/fetch_ctrl.sv
rtl/l1i_top.sv
tb/tb_l1i.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the L1 instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_l1i -f vlog.f -o tb_l1i_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_l1i_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$log_file"; then
   exit 0
else
   echo "pass line not found in $log_file"
   exit 1
fi

//--- tb/tb_l1i.sv
`timescale 1ns/100ps

module tb_l1i;
   import l1i_pkg::*;

   localparam int num_rows = 14;
   localparam int settle_cycles = 80;   // room for three refills after the last pop
   localparam int cycles_per_row = 200;
   localparam logic [31:0] data_key = 32'hA5A5_0000;

   typedef enum int {op_restart, op_consume, op_stall, op_flush} op_t;

   logic clk;
   logic reset;
   logic restart_valid;
   addr_t restart_pc;
   logic restart_ack;
   logic flush_req;
   logic flush_complete;
   logic mem_req_valid;
   addr_t mem_req_addr;
   logic mem_rsp_valid;
   line_t mem_rsp_data;
   logic insn_valid;
   addr_t insn_pc;
   logic [word_w-1:0] insn_data;
   logic insn_ack;

   op_t row_op [num_rows];
   addr_t row_pc [num_rows];
   int row_count [num_rows];
   int row_reqs [num_rows];   // memory requests seen once the row has settled

   int req_count = 0;
   int ack_count = 0;
   int flush_count = 0;
   int popped = 0;
   int pop_target = 0;
   int free_run_target = 0;   // consumer keeps popping until this many acks
   addr_t next_restart_pc = '0;
   addr_t exp_pc = '0;

   l1i_top #(.lg_num_sets(4), .lg_fq_entries(3)) i_dut (.*);

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("** Error at %0t: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
   endtask

   task automatic set_row(input int idx, input op_t op, input addr_t pc, input int count,
                          input int reqs);
      row_op[idx] = op;
      row_pc[idx] = pc;
      row_count[idx] = count;
      row_reqs[idx] = reqs;
   endtask

   // every word holds its own address xor the key
   function automatic line_t make_line(input addr_t line_addr);
      line_t words;
      for (int i = 0; i < words_per_line; i++)
         words[i] = (line_addr + 32'(4 * i)) ^ data_key;
      return words;
   endfunction

   task automatic issue_restart(input addr_t pc);
      int acks_before;
      acks_before = ack_count;
      next_restart_pc = pc;
      free_run_target = ack_count + 1;   // old stream keeps draining until the ack
      restart_valid <= 1'b1;
      restart_pc <= pc;
      @(posedge clk);
      restart_valid <= 1'b0;
      while (ack_count == acks_before)
         @(posedge clk);
   endtask

   task automatic pop_insns(input int count);
      pop_target = popped + count;
      while (popped < pop_target)
         @(posedge clk);
   endtask

   task automatic request_flush();
      int flushes_before;
      flushes_before = flush_count;
      flush_req <= 1'b1;
      @(posedge clk);
      flush_req <= 1'b0;
      while (flush_count == flushes_before)
         @(posedge clk);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // memory model, one line per request
   initial
   begin
      addr_t req_addr;
      int delay;
      mem_rsp_valid <= 1'b0;
      mem_rsp_data <= '0;
      forever
      begin
         @(posedge clk);
         if (!reset && mem_req_valid)
         begin
            req_count++;
            req_addr = mem_req_addr;
            check_equal("mem_req_addr offset", req_addr[lg_line_bytes-1:0], 0);
            delay = 1 + int'($urandom % 6);
            repeat (delay - 1)
               @(posedge clk);
            mem_rsp_valid <= 1'b1;
            mem_rsp_data <= make_line(req_addr);
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
         end
      end
   end

   // consumer with random gaps between acks
   initial
   begin
      insn_ack <= 1'b0;
      forever
      begin
         @(posedge clk);
         if (!reset)
         begin
            if (restart_ack)
            begin
               ack_count++;
               exp_pc = next_restart_pc;   // new stream starts here
            end
            if (flush_complete)
               flush_count++;
            if (insn_ack && insn_valid)
            begin
               check_equal("insn_pc", insn_pc, exp_pc);
               check_equal("insn_data", insn_data, exp_pc ^ data_key);
               exp_pc = exp_pc + 32'd4;
               popped++;
            end
            insn_ack <= ((popped < pop_target) || (ack_count < free_run_target)) &&
                        (($urandom % 3) != 0);
         end
      end
   end

   initial
   begin
      repeat (num_rows * cycles_per_row)
         @(posedge clk);
      stop_with_failure($sformatf("watchdog expired after %0d cycles, the run made no progress",
                                  num_rows * cycles_per_row));
   end

   initial
   begin
      int exp_acks;
      int exp_flushes;
      exp_acks = 0;
      exp_flushes = 0;
      void'($urandom(32'h3337_4446));
      reset <= 1'b1;
      restart_valid <= 1'b0;
      restart_pc <= '0;
      flush_req <= 1'b0;
      // sets 0..10 filled, second pass, then flush and conflict misses
      set_row(0, op_restart, 32'h0000_1000, 0, 3);
      set_row(1, op_consume, 32'h0000_0000, 12, 6);
      set_row(2, op_stall, 32'h0000_0000, 40, 6);
      set_row(3, op_consume, 32'h0000_0000, 20, 11);
      set_row(4, op_restart, 32'h0000_1000, 0, 11);
      set_row(5, op_consume, 32'h0000_0000, 28, 11);
      set_row(6, op_restart, 32'h0000_1058, 0, 11);   // mid line
      set_row(7, op_flush, 32'h0000_0000, 0, 11);
      set_row(8, op_restart, 32'h0000_1000, 0, 14);
      set_row(9, op_consume, 32'h0000_0000, 16, 18);
      set_row(10, op_restart, 32'h0000_10E0, 0, 21);
      set_row(11, op_consume, 32'h0000_0000, 10, 23);
      set_row(12, op_restart, 32'h0000_1000, 0, 26);   // sets 0..2 were replaced
      set_row(13, op_consume, 32'h0000_0000, 8, 26);
      repeat (2)
         @(posedge clk);
      reset <= 1'b0;
      repeat (10)
      begin
         @(posedge clk);
         check_equal("restart_ack", restart_ack, 0);
         check_equal("flush_complete", flush_complete, 0);
         check_equal("mem_req_valid", mem_req_valid, 0);
         check_equal("insn_valid", insn_valid, 0);
      end
      for (int r = 0; r < num_rows; r++)
      begin
         case (row_op[r])
            op_restart:
            begin
               issue_restart(row_pc[r]);
               exp_acks++;
            end
            op_consume: pop_insns(row_count[r]);
            op_stall: repeat (row_count[r]) @(posedge clk);
            default:
            begin
               request_flush();
               exp_flushes++;
            end
         endcase
         repeat (settle_cycles)
            @(posedge clk);
         check_equal("mem request count", req_count, row_reqs[r]);
         check_equal("restart_ack pulses", ack_count, exp_acks);
         check_equal("flush_complete pulses", flush_count, exp_flushes);
         if (row_op[r] == op_flush)
            check_equal("insn_valid", insn_valid, 0);   // no fetch until the next restart
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- rtl/l1i_top.sv
`timescale 1ns/100ps

module l1i_top #(
   parameter int lg_num_sets = 4,
   parameter int lg_fq_entries = 3
)
(
   input logic clk,
   input logic reset,
   input logic restart_valid,
   input l1i_pkg::addr_t restart_pc,
   output logic restart_ack,
   input logic flush_req,
   output logic flush_complete,
   output logic mem_req_valid,
   output l1i_pkg::addr_t mem_req_addr,
   input logic mem_rsp_valid,
   input l1i_pkg::line_t mem_rsp_data,
   output logic insn_valid,
   output l1i_pkg::addr_t insn_pc,
   output logic [l1i_pkg::word_w-1:0] insn_data,
   input logic insn_ack
);
   import l1i_pkg::*;

   logic fq_push;
   fetch_entry_t fq_push_entry;
   logic fq_clear;
   logic fq_full;
   logic fq_empty;
   logic fq_pop;
   fetch_entry_t fq_head;

   icache_if #(.lg_num_sets(lg_num_sets)) cache_bus ();

   fetch_ctrl #(.lg_num_sets(lg_num_sets)) u_ctrl (
      .clk(clk),
      .reset(reset),
      .restart_valid(restart_valid),
      .restart_pc(restart_pc),
      .restart_ack(restart_ack),
      .flush_req(flush_req),
      .flush_complete(flush_complete),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_data(mem_rsp_data),
      .cache(cache_bus),
      .push(fq_push),
      .push_entry(fq_push_entry),
      .clear(fq_clear),
      .full(fq_full)
   );

   icache_arrays #(.lg_num_sets(lg_num_sets)) u_arrays (
      .clk(clk),
      .reset(reset),
      .cache(cache_bus)
   );

   fetch_queue #(.lg_fq_entries(lg_fq_entries)) u_fq (
      .clk(clk),
      .reset(reset),
      .push(fq_push),
      .push_entry(fq_push_entry),
      .pop(fq_pop),
      .clear(fq_clear),
      .full(fq_full),
      .empty(fq_empty),
      .head(fq_head)
   );

   assign insn_valid = !fq_empty;
   assign fq_pop = insn_ack && insn_valid;   // ack ignored on an empty queue
   assign insn_pc = fq_head.pc;
   assign insn_data = fq_head.data;

endmodule

//--- rtl/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl #(parameter int lg_num_sets = 4)
(
   input logic clk,
   input logic reset,
   input logic restart_valid,
   input l1i_pkg::addr_t restart_pc,
   output logic restart_ack,
   input logic flush_req,
   output logic flush_complete,
   output logic mem_req_valid,
   output l1i_pkg::addr_t mem_req_addr,
   input logic mem_rsp_valid,
   input l1i_pkg::line_t mem_rsp_data,
   icache_if.ctrl cache,
   output logic push,
   output l1i_pkg::fetch_entry_t push_entry,
   output logic clear,
   input logic full
);
   import l1i_pkg::*;

   fetch_state_t r_state, n_state;
   addr_t r_pc, n_pc;               // next pc to look up
   addr_t r_cache_pc, n_cache_pc;   // pc under lookup
   addr_t r_miss_pc, n_miss_pc;     // pc to retry after miss or full queue
   addr_t r_restart_pc;
   addr_t r_mem_req_addr, n_mem_req_addr;
   logic r_req, n_req;
   logic r_restart_req, n_restart_req;
   logic r_flush_req, n_flush_req;
   logic r_restart_ack;
   logic r_flush_complete, n_flush_complete;
   logic r_mem_req_valid, n_mem_req_valid;
   logic [lg_num_sets-1:0] r_flush_idx, n_flush_idx;

   logic t_can_redirect;
   logic t_take_flush;
   logic t_take_restart;
   logic t_miss;
   logic t_lookup;
   addr_t t_lookup_pc;

   assign restart_ack = r_restart_ack;
   assign flush_complete = r_flush_complete;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = r_mem_req_addr;

   assign cache.lookup_en = t_lookup;
   assign cache.lookup_pc = t_lookup_pc;
   assign cache.fill_en = (r_state == INJECT_RELOAD) && mem_rsp_valid;
   assign cache.fill_addr = r_mem_req_addr;
   assign cache.fill_line = mem_rsp_data;
   assign cache.flush_en = (r_state == FLUSH_CACHE);
   assign cache.flush_idx = r_flush_idx;

   assign push_entry.pc = r_cache_pc;
   assign push_entry.data = cache.hit_word;

   // a pending flush holds off any restart
   assign t_can_redirect = (r_state != INJECT_RELOAD) && (r_state != FLUSH_CACHE);
   assign t_take_flush = t_can_redirect && r_flush_req;
   assign t_take_restart = t_can_redirect && r_restart_req && !r_flush_req;
   assign t_miss = r_req && !cache.hit;
   assign clear = t_take_flush || t_take_restart;

   assign n_restart_req = restart_valid || (r_restart_req && !t_take_restart);
   assign n_flush_req = flush_req || (r_flush_req && !t_take_flush);

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_req = 1'b0;
      n_mem_req_valid = 1'b0;
      n_mem_req_addr = r_mem_req_addr;
      n_flush_idx = r_flush_idx;
      n_flush_complete = 1'b0;
      t_lookup = 1'b0;
      t_lookup_pc = r_pc;
      push = 1'b0;
      if (t_take_flush)
      begin
         n_state = FLUSH_CACHE;
         n_flush_idx = '0;
      end
      else if (t_take_restart)
      begin
         n_state = ACTIVE;
         n_pc = r_restart_pc;
      end
      else
      begin
         case (r_state)
            ACTIVE:
            begin
               if (t_miss)
               begin
                  n_state = INJECT_RELOAD;
                  n_miss_pc = r_cache_pc;
                  n_mem_req_valid = 1'b1;
                  n_mem_req_addr = {r_cache_pc[addr_w-1:lg_line_bytes], {lg_line_bytes{1'b0}}};
               end
               else if (cache.hit && full)
               begin
                  n_state = WAIT_FOR_NOT_FULL;
                  n_miss_pc = r_cache_pc;
               end
               else
               begin
                  push = cache.hit;
                  t_lookup = 1'b1;
               end
            end
            INJECT_RELOAD:
               if (mem_rsp_valid)
                  n_state = RELOAD_TURNAROUND;
            RELOAD_TURNAROUND:
            begin
               t_lookup = 1'b1;
               t_lookup_pc = r_miss_pc;
               n_state = ACTIVE;
            end
            WAIT_FOR_NOT_FULL:
               if (!full)
               begin
                  t_lookup = 1'b1;
                  t_lookup_pc = r_miss_pc;
                  n_state = ACTIVE;
               end
            FLUSH_CACHE:
            begin
               n_flush_idx = r_flush_idx + 1'b1;
               if (&r_flush_idx)
               begin
                  n_flush_complete = 1'b1;
                  n_state = IDLE;
               end
            end
            default:
            begin
            end
         endcase
      end
      if (t_lookup)
      begin
         n_req = 1'b1;
         n_cache_pc = t_lookup_pc;
         n_pc = t_lookup_pc + 32'd4;   // no prediction, always sequential
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_flush_idx <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_req <= n_req;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_restart_ack <= t_take_restart;
         r_flush_complete <= n_flush_complete;
         r_mem_req_valid <= n_mem_req_valid;
         r_flush_idx <= n_flush_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_cache_pc <= n_cache_pc;
      r_miss_pc <= n_miss_pc;
      r_mem_req_addr <= n_mem_req_addr;
      if (restart_valid)
         r_restart_pc <= restart_pc;
   end

endmodule

//--- rtl/fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue #(parameter int lg_fq_entries = 3)
(
   input logic clk,
   input logic reset,
   input logic push,
   input l1i_pkg::fetch_entry_t push_entry,
   input logic pop,
   input logic clear,
   output logic full,
   output logic empty,
   output l1i_pkg::fetch_entry_t head
);
   import l1i_pkg::*;

   localparam int num_entries = 1 << lg_fq_entries;

   fetch_entry_t r_entries [num_entries];

   // extra msb tells a full ring from an empty one
   logic [lg_fq_entries:0] r_head_ptr;
   logic [lg_fq_entries:0] r_tail_ptr;

   assign empty = (r_head_ptr == r_tail_ptr);
   assign full = (r_head_ptr[lg_fq_entries] != r_tail_ptr[lg_fq_entries]) &&
                 (r_head_ptr[lg_fq_entries-1:0] == r_tail_ptr[lg_fq_entries-1:0]);

   assign head = r_entries[r_head_ptr[lg_fq_entries-1:0]];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         if (push)
            r_tail_ptr <= r_tail_ptr + 1'b1;
         if (pop)
            r_head_ptr <= r_head_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push && !clear)
         r_entries[r_tail_ptr[lg_fq_entries-1:0]] <= push_entry;
   end

   // consumer side is gated by insn_valid at the top level
   assert property (@(posedge clk) disable iff (reset) !(pop && empty));

   // a push into a full ring would overwrite the oldest entry
   assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

//--- rtl/icache_arrays.sv
`timescale 1ns/100ps

module icache_arrays #(parameter int lg_num_sets = 4)
(
   input logic clk,
   input logic reset,
   icache_if.arrays cache
);
   import l1i_pkg::*;

   localparam int num_sets = 1 << lg_num_sets;
   localparam int idx_hi = lg_line_bytes + lg_num_sets;
   localparam int tag_w = addr_w - idx_hi;

   logic [num_sets-1:0] r_valid;
   logic [tag_w-1:0] r_tags [num_sets];
   line_t r_lines [num_sets];

   // lookup address split, held for the decide cycle
   logic r_lookup;
   logic [lg_num_sets-1:0] r_idx;
   logic [tag_w-1:0] r_tag;
   logic [lg_words_per_line-1:0] r_word;

   logic [lg_num_sets-1:0] t_fill_idx;

   assign t_fill_idx = cache.fill_addr[idx_hi-1:lg_line_bytes];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= '0;
         r_lookup <= 1'b0;
      end
      else
      begin
         r_lookup <= cache.lookup_en;
         if (cache.fill_en)
            r_valid[t_fill_idx] <= 1'b1;
         else if (cache.flush_en)
            r_valid[cache.flush_idx] <= 1'b0;   // one set per cycle
      end
   end

   always_ff @(posedge clk)
   begin
      if (cache.lookup_en)
      begin
         r_idx <= cache.lookup_pc[idx_hi-1:lg_line_bytes];
         r_tag <= cache.lookup_pc[addr_w-1:idx_hi];
         r_word <= cache.lookup_pc[lg_line_bytes-1:2];
      end
      if (cache.fill_en)
      begin
         r_tags[t_fill_idx] <= cache.fill_addr[addr_w-1:idx_hi];
         r_lines[t_fill_idx] <= cache.fill_line;
      end
   end

   assign cache.hit = r_lookup && r_valid[r_idx] && (r_tags[r_idx] == r_tag);
   assign cache.hit_word = r_lines[r_idx][r_word];

   // refill only happens while waiting on memory, flush walk has the arrays alone
   assert property (@(posedge clk) disable iff (reset) !(cache.fill_en && cache.flush_en));

endmodule

//--- rtl/icache_if.sv
`timescale 1ns/100ps

interface icache_if #(parameter int lg_num_sets = 4);
   import l1i_pkg::*;

   logic lookup_en;
   addr_t lookup_pc;

   logic fill_en;
   addr_t fill_addr;           // line aligned
   line_t fill_line;

   logic flush_en;
   logic [lg_num_sets-1:0] flush_idx;

   // answer to the lookup of the previous cycle
   logic hit;
   logic [word_w-1:0] hit_word;

   modport ctrl (output lookup_en, lookup_pc, fill_en, fill_addr, fill_line,
                 output flush_en, flush_idx, input hit, hit_word);

   modport arrays (input lookup_en, lookup_pc, fill_en, fill_addr, fill_line,
                   input flush_en, flush_idx, output hit, hit_word);

endinterface

//--- rtl/l1i_pkg.sv
package l1i_pkg;

   localparam int addr_w = 32;
   localparam int word_w = 32;

   // 16-byte lines, four instruction words each
   localparam int lg_line_bytes = 4;
   localparam int lg_words_per_line = lg_line_bytes - 2;
   localparam int words_per_line = 1 << lg_words_per_line;

   typedef logic [addr_w-1:0] addr_t;

   // word 0 sits in the low bits of the line
   typedef logic [words_per_line-1:0][word_w-1:0] line_t;

   typedef struct packed
   {
      addr_t pc;
      logic [word_w-1:0] data;
   } fetch_entry_t;

   typedef enum logic [2:0]
   {
      IDLE              = 3'd0,
      ACTIVE            = 3'd1,
      INJECT_RELOAD     = 3'd2,  // miss outstanding to memory
      RELOAD_TURNAROUND = 3'd3,
      FLUSH_CACHE       = 3'd4,
      WAIT_FOR_NOT_FULL = 3'd5
   } fetch_state_t;

endpackage
